//--- sources.f
rtl/pkt_gen_pkg.sv
rtl/signal_delay_line.sv
rtl/link_event_decode.sv
rtl/pkt_sequencer.sv
rtl/beat_formatter.sv
rtl/status_indicators.sv
rtl/pkt_gen_top.sv
verification/pkt_gen_chk.sv
verification/pkt_gen_tb.sv

//--- Bender.yml
package:
  name: pkt_gen

sources:
  - rtl/pkt_gen_pkg.sv
  - rtl/signal_delay_line.sv
  - rtl/link_event_decode.sv
  - rtl/pkt_sequencer.sv
  - rtl/beat_formatter.sv
  - rtl/status_indicators.sv
  - rtl/pkt_gen_top.sv
  - target: simulation
    files:
      - verification/pkt_gen_chk.sv
      - verification/pkt_gen_tb.sv

//--- verification/pkt_gen_tb.sv
`timescale 1ns/1ps

module pkt_gen_tb;

    localparam int PKT_NUM  = 5;
    localparam int PKT_SIZE = 150;
    localparam int BYTES    = pkt_gen_pkg::BEAT_BYTES;
    localparam int BEATS    = (PKT_SIZE + BYTES - 1) / BYTES;
    localparam int TAIL     = PKT_SIZE % BYTES;
    localparam int WORDS    = pkt_gen_pkg::DATA_W / 32;

    logic                           clk;
    logic                           sys_reset;
    pkt_gen_pkg::link_status_t      link_status;
    logic                           send_continuous_pkts;
    logic                           restart_in;
    logic                           tx_axis_tready;
    logic [pkt_gen_pkg::DATA_W-1:0] src_tdata;
    pkt_gen_pkg::axis_beat_t        tx_axis;
    pkt_gen_pkg::mac_ctl_t          mac_ctl;
    pkt_gen_pkg::led_t              leds;

    // reference model state
    logic [pkt_gen_pkg::DATA_W-1:0] sampled_data;
    int                             beat_idx;
    int                             pkts;
    logic                           hold_tready_low;

    pkt_gen_top #(
        .PKT_NUM  (PKT_NUM),
        .PKT_SIZE (PKT_SIZE)
    ) pkt_gen_top_inst (
        .clk                  (clk),
        .sys_reset            (sys_reset),
        .link_status          (link_status),
        .send_continuous_pkts (send_continuous_pkts),
        .restart_in           (restart_in),
        .tx_axis_tready       (tx_axis_tready),
        .src_tdata            (src_tdata),
        .tx_axis              (tx_axis),
        .mac_ctl              (mac_ctl),
        .leds                 (leds)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #20 clk = ~clk;
    end

    ////////////////////
    // failure reporting and compares
    task automatic stop_with_failure();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic report_problem(string why);
        $display("[ERROR] %0t ns: %s", $time, why);
        stop_with_failure();
    endtask

    task automatic check_beat(pkt_gen_pkg::axis_beat_t got, pkt_gen_pkg::axis_beat_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns: tx_axis is %h, expected %h", $time, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_leds(pkt_gen_pkg::led_t got, pkt_gen_pkg::led_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns: leds is %b, expected %b", $time, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_mac(pkt_gen_pkg::mac_ctl_t got, pkt_gen_pkg::mac_ctl_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns: mac_ctl is %b, expected %b", $time, got, exp);
            stop_with_failure();
        end
    endtask

    // full keep except the tail of the final beat
    function automatic pkt_gen_pkg::axis_beat_t expected_beat(
        int idx,
        logic [pkt_gen_pkg::DATA_W-1:0] data
    );
        pkt_gen_pkg::axis_beat_t b;
        int i;
        b.tdata  = data;
        b.tvalid = 1'b1;
        b.tlast  = (idx == BEATS - 1);
        b.tkeep  = '1;
        if (b.tlast && TAIL != 0)
        begin
            b.tkeep = '0;
            for (i = 0; i < TAIL; i++)
                b.tkeep[i] = 1'b1;
        end
        return b;
    endfunction

    ////////////////////
    // monitor and model
    always @(posedge clk)
    begin
        if (!sys_reset)
        begin
            if (pkt_gen_top_inst.pkt_gen_chk_inst.assert_failures != 0)
                report_problem("a protocol assertion on tx_axis failed");
            if (tx_axis.tvalid && tx_axis_tready)
            begin
                check_beat(tx_axis, expected_beat(beat_idx, sampled_data));
                check_mac(mac_ctl, pkt_gen_pkg::mac_ctl_t'{ctl_tx_enable: 1'b1,
                                                           ctl_tx_send_rfi: 1'b0});
                if (tx_axis.tlast)
                begin
                    beat_idx = 0;
                    pkts++;
                end
                else
                    beat_idx++;
            end
            if (tx_axis_tready)
                sampled_data = src_tdata;
        end
    end

    ////////////////////
    // stimulus and waits
    task automatic step();
        int w;
        @(negedge clk);
        if (hold_tready_low)
            tx_axis_tready = 1'b0;
        else
            tx_axis_tready = ($urandom % 4) != 0;
        for (w = 0; w < WORDS; w++)
            src_tdata[w*32 +: 32] = $urandom;
    endtask

    task automatic wait_rfi_high(int limit);
        int n;
        n = 0;
        while (!mac_ctl.ctl_tx_send_rfi)
        begin
            step();
            n++;
            if (n > limit)
                report_problem("timed out waiting for ctl_tx_send_rfi");
        end
    endtask

    task automatic wait_packets(int count, int limit);
        int n;
        n = 0;
        while (pkts < count)
        begin
            step();
            n++;
            if (n > limit)
                report_problem("timed out waiting for packets on tx_axis");
        end
    endtask

    task automatic wait_done_led(logic level, int limit);
        int n;
        n = 0;
        while (leds.done !== level)
        begin
            step();
            n++;
            if (n > limit)
                report_problem("timed out waiting for the done LED");
        end
    endtask

    task automatic restart_run();
        pkts = 0;
        step();
        restart_in = 1'b1;
        repeat (3) step();
        restart_in = 1'b0;
        wait_done_led(1'b0, 100);
        check_leds(leds, pkt_gen_pkg::led_t'{gt_locked: 1'b1, done: 1'b0, busy: 1'b1});
    endtask

    task automatic finish_run(bit exact);
        wait_done_led(1'b1, 4000);
        check_leds(leds, pkt_gen_pkg::led_t'{gt_locked: 1'b1, done: 1'b1, busy: 1'b0});
        repeat (30)
        begin
            step();
            if (tx_axis.tvalid)
                report_problem("tvalid rose after the run ended");
        end
        if (beat_idx != 0)
            report_problem("the run ended inside a packet");
        if (exact && pkts != PKT_NUM)
            report_problem($sformatf("run sent %0d packets instead of %0d", pkts, PKT_NUM));
    endtask

    initial
    begin
        void'($urandom(73219));
        sys_reset            = 1'b1;
        link_status          = '0;
        send_continuous_pkts = 1'b0;
        restart_in           = 1'b0;
        tx_axis_tready       = 1'b0;
        src_tdata            = '0;
        sampled_data         = '0;
        beat_idx             = 0;
        pkts                 = 0;
        hold_tready_low      = 1'b0;

        repeat (10) @(posedge clk);
        @(negedge clk);
        if (tx_axis.tvalid !== 1'b0)
            report_problem("tvalid is not low in reset");
        check_mac(mac_ctl, '0);
        check_leds(leds, '0);
        sys_reset = 1'b0;

        // remote fault until aligned
        wait_rfi_high(20);
        repeat (20)
        begin
            step();
            check_mac(mac_ctl, pkt_gen_pkg::mac_ctl_t'{ctl_tx_enable: 1'b0,
                                                       ctl_tx_send_rfi: 1'b1});
            if (tx_axis.tvalid)
                report_problem("tvalid high before alignment");
        end

        link_status.rx_aligned = 1'b1;
        finish_run(1'b1);

        restart_run();
        finish_run(1'b1);

        send_continuous_pkts = 1'b1;
        restart_run();
        wait_packets(2 * PKT_NUM + 1, 4000);
        send_continuous_pkts = 1'b0;
        finish_run(1'b0);

        // one-cycle overflow with tready held off around it
        restart_run();
        wait_packets(2, 3000);
        hold_tready_low = 1'b1;
        step();
        link_status.tx_ovf = 1'b1;
        step();
        link_status.tx_ovf = 1'b0;
        repeat (3) step();
        hold_tready_low = 1'b0;
        finish_run(1'b1);

        restart_run();
        wait_packets(1, 3000);
        step();
        link_status.rx_aligned = 1'b0;
        wait_rfi_high(50);
        check_mac(mac_ctl, pkt_gen_pkg::mac_ctl_t'{ctl_tx_enable: 1'b0, ctl_tx_send_rfi: 1'b1});
        if (tx_axis.tvalid)
            report_problem("tvalid still high after alignment loss");
        beat_idx = 0;

        repeat (5) step();
        if (pkt_gen_top_inst.pkt_gen_chk_inst.assert_failures == 0)
        begin
            $display("Testbench passed");
            $finish;
        end
        else
            report_problem("a protocol assertion on tx_axis failed");
    end

endmodule

//--- verification/pkt_gen_chk.sv
`timescale 1ns/1ps

module pkt_gen_chk (
    input  logic                      clk,
    input  logic                      sys_reset,
    input  pkt_gen_pkg::link_status_t link_status,
    input  logic                      tx_axis_tready,
    input  pkt_gen_pkg::axis_beat_t   tx_axis,
    input  pkt_gen_pkg::mac_ctl_t     mac_ctl
);

    int assert_failures = 0;

    ////////////////////
    // streaming port rules
    keep_nonzero: assert property (@(posedge clk) disable iff (sys_reset)
        tx_axis.tvalid |-> (tx_axis.tkeep != '0))
    else
    begin
        assert_failures++;
        $error("tkeep is zero on a valid beat");
    end

    // off while alignment loss aborts the beat
    beat_held: assert property (@(posedge clk)
        disable iff (sys_reset || !link_status.rx_aligned)
        (tx_axis.tvalid && !tx_axis_tready) |=> $stable(tx_axis))
    else
    begin
        assert_failures++;
        $error("beat changed under back-pressure");
    end

    idle_when_disabled: assert property (@(posedge clk) disable iff (sys_reset)
        !mac_ctl.ctl_tx_enable |-> !tx_axis.tvalid)
    else
    begin
        assert_failures++;
        $error("tvalid high while the transmitter is disabled");
    end

endmodule

bind pkt_gen_top pkt_gen_chk pkt_gen_chk_inst (
    .clk            (clk),
    .sys_reset      (sys_reset),
    .link_status    (link_status),
    .tx_axis_tready (tx_axis_tready),
    .tx_axis        (tx_axis),
    .mac_ctl        (mac_ctl)
);

//--- rtl/pkt_gen_top.sv
`timescale 1ns/1ps

module pkt_gen_top #(
    parameter int PKT_NUM  = 1000,
    parameter int PKT_SIZE = 522
) (
    input  logic                           clk,
    input  logic                           sys_reset,
    input  pkt_gen_pkg::link_status_t      link_status,
    input  logic                           send_continuous_pkts,
    input  logic                           restart_in,
    input  logic                           tx_axis_tready,
    input  logic [pkt_gen_pkg::DATA_W-1:0] src_tdata,
    output pkt_gen_pkg::axis_beat_t        tx_axis,
    output pkt_gen_pkg::mac_ctl_t          mac_ctl,
    output pkt_gen_pkg::led_t              leds
);

    pkt_gen_pkg::link_events_t events;
    pkt_gen_pkg::seq_ctrl_t    ctrl;
    pkt_gen_pkg::seq_report_t  report;
    logic                      pkt_end;
    logic                      drained;

    link_event_decode link_event_decode_inst (
        .clk                  (clk),
        .sys_reset            (sys_reset),
        .status               (link_status),
        .send_continuous_pkts (send_continuous_pkts),
        .restart_in           (restart_in),
        .events               (events)
    );

    pkt_sequencer #(
        .PKT_NUM (PKT_NUM)
    ) pkt_sequencer_inst (
        .clk       (clk),
        .sys_reset (sys_reset),
        .events    (events),
        .tready    (tx_axis_tready),
        .pkt_end   (pkt_end),
        .drained   (drained),
        .ctrl      (ctrl),
        .report    (report),
        .mac_ctl   (mac_ctl)
    );

    beat_formatter #(
        .PKT_SIZE (PKT_SIZE)
    ) beat_formatter_inst (
        .clk       (clk),
        .sys_reset (sys_reset),
        .ctrl      (ctrl),
        .tready    (tx_axis_tready),
        .src_tdata (src_tdata),
        .beat      (tx_axis),
        .pkt_end   (pkt_end),
        .drained   (drained)
    );

    status_indicators status_indicators_inst (
        .clk       (clk),
        .sys_reset (sys_reset),
        .report    (report),
        .leds      (leds)
    );

endmodule

//--- rtl/status_indicators.sv
`timescale 1ns/1ps

module status_indicators (
    input  logic                     clk,
    input  logic                     sys_reset,
    input  pkt_gen_pkg::seq_report_t report,
    output pkt_gen_pkg::led_t        leds
);

    logic              done_q;
    pkt_gen_pkg::led_t led_src;
    pkt_gen_pkg::led_t led_dly;

    // sticky until the next run starts
    always_ff @(posedge clk or posedge sys_reset)
    begin
        if (sys_reset)
            done_q <= 1'b0;
        else if (report.run_start)
            done_q <= 1'b0;
        else if (report.run_done)
            done_q <= 1'b1;
    end

    assign led_src = '{
        gt_locked: report.gt_locked,
        done:      done_q,
        busy:      report.busy
    };

    signal_delay_line #(
        .T     (pkt_gen_pkg::led_t),
        .DEPTH (pkt_gen_pkg::LED_STAGES)
    ) led_delay_inst (
        .clk       (clk),
        .sys_reset (sys_reset),
        .d         (led_src),
        .q         (led_dly)
    );

    // output register
    always_ff @(posedge clk or posedge sys_reset)
    begin
        if (sys_reset)
            leds <= '0;
        else
            leds <= led_dly;
    end

endmodule

//--- rtl/beat_formatter.sv
`timescale 1ns/1ps

module beat_formatter #(
    parameter int PKT_SIZE = 522
) (
    input  logic                           clk,
    input  logic                           sys_reset,
    input  pkt_gen_pkg::seq_ctrl_t         ctrl,
    input  logic                           tready,
    input  logic [pkt_gen_pkg::DATA_W-1:0] src_tdata,
    output pkt_gen_pkg::axis_beat_t        beat,
    output logic                           pkt_end,
    output logic                           drained
);

    localparam int SW   = pkt_gen_pkg::SIZE_W;
    localparam int KW   = pkt_gen_pkg::KEEP_W;
    localparam int TAIL = PKT_SIZE % pkt_gen_pkg::BEAT_BYTES;

    localparam logic [SW-1:0] FULL_SIZE  = SW'(PKT_SIZE);
    localparam logic [SW-1:0] BEAT_SIZE  = SW'(pkt_gen_pkg::BEAT_BYTES);
    localparam logic [KW-1:0] LAST_KEEP  = (TAIL == 0) ? {KW{1'b1}} : (KW'(1) << TAIL) - 1'b1;

    logic [SW-1:0]                  remaining;
    logic                           last_beat;
    logic                           load;
    logic                           abort;
    logic                           tvalid_q;
    logic                           tlast_q;
    logic [pkt_gen_pkg::DATA_W-1:0] tdata_q;
    logic [KW-1:0]                  tkeep_q;

    assign abort     = ctrl.advance & ctrl.finish;
    assign load      = ctrl.advance & ~ctrl.finish & tready;
    assign last_beat = (remaining <= BEAT_SIZE);
    assign pkt_end   = load & last_beat;
    assign drained   = ~tvalid_q;

    ////////////////////
    // valid, last, byte countdown
    always_ff @(posedge clk or posedge sys_reset)
    begin
        if (sys_reset)
        begin
            tvalid_q  <= 1'b0;
            tlast_q   <= 1'b0;
            remaining <= FULL_SIZE;
        end
        else if (abort)
        begin
            tvalid_q  <= 1'b0;
            tlast_q   <= 1'b0;
            remaining <= FULL_SIZE;
        end
        else if (load)
        begin
            tvalid_q  <= 1'b1;
            tlast_q   <= last_beat;
            remaining <= last_beat ? FULL_SIZE : remaining - BEAT_SIZE;
        end
        else if (ctrl.finish && tready)
        begin
            tvalid_q <= 1'b0;
            tlast_q  <= 1'b0;
        end
    end

    // payload only moves on a load
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            tdata_q <= src_tdata;
            tkeep_q <= last_beat ? LAST_KEEP : {KW{1'b1}};
        end
    end

    assign beat = '{tdata: tdata_q, tkeep: tkeep_q, tlast: tlast_q, tvalid: tvalid_q};

endmodule

//--- rtl/pkt_sequencer.sv
`timescale 1ns/1ps

module pkt_sequencer #(
    parameter int PKT_NUM = 1000
) (
    input  logic                      clk,
    input  logic                      sys_reset,
    input  pkt_gen_pkg::link_events_t events,
    input  logic                      tready,
    input  logic                      pkt_end,
    input  logic                      drained,
    output pkt_gen_pkg::seq_ctrl_t    ctrl,
    output pkt_gen_pkg::seq_report_t  report,
    output pkt_gen_pkg::mac_ctl_t     mac_ctl
);

    localparam int CW     = pkt_gen_pkg::COUNT_W;
    localparam int WAIT_W = $clog2(pkt_gen_pkg::INIT_WAIT_CYCLES + 1);

    localparam logic [CW-1:0]     LAST_PKT = CW'(PKT_NUM - 1);
    localparam logic [CW-1:0]     SAT_PKT  = CW'(PKT_NUM);
    localparam logic [WAIT_W-1:0] WAIT_END = WAIT_W'(pkt_gen_pkg::INIT_WAIT_CYCLES);

    pkt_gen_pkg::seq_state_e state_q;
    pkt_gen_pkg::seq_state_e state_d;
    logic [WAIT_W-1:0]       wait_cnt;
    logic [CW-1:0]           pkt_cnt;
    logic                    tready_q;
    logic                    init_done;
    logic                    last_pkt;
    logic                    run_end;
    logic                    link_up;

    assign init_done = (wait_cnt == WAIT_END);
    assign last_pkt  = (pkt_cnt >= LAST_PKT);
    assign run_end   = pkt_end & last_pkt & ~events.continuous;
    assign link_up   = !(state_q inside {pkt_gen_pkg::IDLE, pkt_gen_pkg::GT_LOCKED,
                                         pkt_gen_pkg::WAIT_ALIGNED});

    ////////////////////
    // next state
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            pkt_gen_pkg::IDLE:
                state_d = pkt_gen_pkg::GT_LOCKED;
            pkt_gen_pkg::GT_LOCKED:
                state_d = pkt_gen_pkg::WAIT_ALIGNED;
            pkt_gen_pkg::WAIT_ALIGNED:
                if (events.aligned)
                    state_d = pkt_gen_pkg::XFER_INIT;
            pkt_gen_pkg::XFER_INIT:
                if (init_done && tready_q && !events.fault)
                    state_d = pkt_gen_pkg::STREAM;
            pkt_gen_pkg::STREAM:
                // the final last beat wins over a fault
                if (run_end)
                    state_d = pkt_gen_pkg::DRAIN;
                else if (events.fault)
                    state_d = pkt_gen_pkg::HALT;
            pkt_gen_pkg::HALT:
                if (events.fault)
                    state_d = pkt_gen_pkg::DRAIN;
                else
                    state_d = pkt_gen_pkg::STREAM;
            pkt_gen_pkg::DRAIN:
                if (drained)
                    state_d = pkt_gen_pkg::DONE;
            pkt_gen_pkg::DONE:
                state_d = pkt_gen_pkg::WAIT_RESTART;
            pkt_gen_pkg::WAIT_RESTART:
                if (events.restart)
                    state_d = pkt_gen_pkg::XFER_INIT;
            default:
                state_d = pkt_gen_pkg::IDLE;
        endcase

        // alignment lost
        if (link_up && !events.aligned)
            state_d = pkt_gen_pkg::IDLE;
    end

    ////////////////////
    // state, counters, mac controls
    always_ff @(posedge clk or posedge sys_reset)
    begin
        if (sys_reset)
        begin
            state_q  <= pkt_gen_pkg::IDLE;
            tready_q <= 1'b0;
            wait_cnt <= '0;
            pkt_cnt  <= '0;
            mac_ctl  <= '0;
        end
        else
        begin
            state_q  <= state_d;
            tready_q <= tready;

            if (state_q != pkt_gen_pkg::XFER_INIT)
                wait_cnt <= '0;
            else if (!init_done)
                wait_cnt <= wait_cnt + 1'b1;

            if (state_q == pkt_gen_pkg::XFER_INIT)
                pkt_cnt <= '0;
            else if (pkt_end && pkt_cnt != SAT_PKT)
                pkt_cnt <= pkt_cnt + 1'b1;

            // one cycle behind the state so the beat clears first
            mac_ctl.ctl_tx_enable   <= link_up;
            mac_ctl.ctl_tx_send_rfi <= state_q inside {pkt_gen_pkg::GT_LOCKED,
                                                       pkt_gen_pkg::WAIT_ALIGNED};
        end
    end

    always_comb
    begin
        case (state_q)
            pkt_gen_pkg::STREAM:
                ctrl = '{advance: 1'b1, finish: 1'b0};
            pkt_gen_pkg::HALT:
                ctrl = '{advance: 1'b0, finish: 1'b0};
            pkt_gen_pkg::DRAIN:
                ctrl = '{advance: 1'b0, finish: 1'b1};
            default:
                ctrl = '{advance: 1'b1, finish: 1'b1};
        endcase
    end

    assign report = '{
        gt_locked: state_q != pkt_gen_pkg::IDLE,
        busy:      state_q inside {pkt_gen_pkg::XFER_INIT, pkt_gen_pkg::STREAM,
                                   pkt_gen_pkg::HALT, pkt_gen_pkg::DRAIN, pkt_gen_pkg::DONE},
        run_start: (state_q == pkt_gen_pkg::WAIT_RESTART) && events.restart,
        run_done:  state_q == pkt_gen_pkg::DONE
    };

endmodule

//--- rtl/link_event_decode.sv
`timescale 1ns/1ps

module link_event_decode (
    input  logic                      clk,
    input  logic                      sys_reset,
    input  pkt_gen_pkg::link_status_t status,
    input  logic                      send_continuous_pkts,
    input  logic                      restart_in,
    output pkt_gen_pkg::link_events_t events
);

    pkt_gen_pkg::link_status_t status_q;
    logic                      continuous_q;
    logic                      restart_q;
    logic                      restart_last;
    logic                      restart_pulse;

    signal_delay_line #(
        .T     (pkt_gen_pkg::link_status_t),
        .DEPTH (pkt_gen_pkg::STATUS_SYNC_STAGES)
    ) status_sync_inst (
        .clk       (clk),
        .sys_reset (sys_reset),
        .d         (status),
        .q         (status_q)
    );

    signal_delay_line #(
        .T     (logic),
        .DEPTH (pkt_gen_pkg::MODE_SYNC_STAGES)
    ) mode_sync_inst (
        .clk       (clk),
        .sys_reset (sys_reset),
        .d         (send_continuous_pkts),
        .q         (continuous_q)
    );

    signal_delay_line #(
        .T     (logic),
        .DEPTH (pkt_gen_pkg::RESTART_SYNC_STAGES)
    ) restart_sync_inst (
        .clk       (clk),
        .sys_reset (sys_reset),
        .d         (restart_in),
        .q         (restart_q)
    );

    // rising edge of the last restart stage
    always_ff @(posedge clk or posedge sys_reset)
    begin
        if (sys_reset)
        begin
            restart_last  <= 1'b0;
            restart_pulse <= 1'b0;
        end
        else
        begin
            restart_last  <= restart_q;
            restart_pulse <= restart_q & ~restart_last;
        end
    end

    assign events = '{
        aligned:    status_q.rx_aligned,
        fault:      status_q.tx_ovf | status_q.tx_unf,
        continuous: continuous_q,
        restart:    restart_pulse
    };

endmodule

//--- rtl/signal_delay_line.sv
`timescale 1ns/1ps

module signal_delay_line #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic sys_reset,
    input  T     d,
    output T     q
);

    T stage [DEPTH];

    always_ff @(posedge clk or posedge sys_reset)
    begin
        if (sys_reset)
        begin
            for (int i = 0; i < DEPTH; i++)
                stage[i] <= '0;
        end
        else
        begin
            stage[0] <= d;
            // shift toward the output end
            for (int i = 1; i < DEPTH; i++)
                stage[i] <= stage[i-1];
        end
    end

    assign q = stage[DEPTH-1];

endmodule

//--- rtl/pkt_gen_pkg.sv
package pkt_gen_pkg;

    localparam int DATA_W     = 512;
    localparam int KEEP_W     = 64;
    localparam int BEAT_BYTES = 64;
    localparam int SIZE_W     = 14;
    localparam int COUNT_W    = 16;

    localparam int INIT_WAIT_CYCLES = 16;

    // register stages per path
    localparam int STATUS_SYNC_STAGES  = 1;
    localparam int MODE_SYNC_STAGES    = 3;
    localparam int RESTART_SYNC_STAGES = 4;
    localparam int LED_STAGES          = 3;

    typedef enum logic [3:0] {
        IDLE,
        GT_LOCKED,
        WAIT_ALIGNED,
        XFER_INIT,
        STREAM,
        HALT,
        DRAIN,
        DONE,
        WAIT_RESTART
    } seq_state_e;

    typedef struct packed {
        logic rx_aligned;
        logic tx_ovf;
        logic tx_unf;
    } link_status_t;

    typedef struct packed {
        logic aligned;
        logic fault;
        logic continuous;
        logic restart;
    } link_events_t;

    // advance and finish together abort the current beat
    typedef struct packed {
        logic advance;
        logic finish;
    } seq_ctrl_t;

    typedef struct packed {
        logic gt_locked;
        logic busy;
        logic run_start;
        logic run_done;
    } seq_report_t;

    typedef struct packed {
        logic gt_locked;
        logic done;
        logic busy;
    } led_t;

    typedef struct packed {
        logic [DATA_W-1:0] tdata;
        logic [KEEP_W-1:0] tkeep;
        logic              tlast;
        logic              tvalid;
    } axis_beat_t;

    typedef struct packed {
        logic ctl_tx_enable;
        logic ctl_tx_send_rfi;
    } mac_ctl_t;

endpackage
